//--- Makefile
TOP := cdcFifoTb

.PHONY: all lint sim clean

all: sim

lint:
	verilator --lint-only --timing --assert --timescale 1ns/1ps -f flist.f --top-module $(TOP)

sim:
	verilator --binary --timing --assert --timescale 1ns/1ps -f flist.f --top-module $(TOP) -o $(TOP)
	./obj_dir/$(TOP) +verilator+error+limit+100 2>&1 | tee sim.log
	@grep -q "ALL CHECKS PASSED" sim.log || (echo "Simulation failed, see sim.log"; exit 1)

clean:
	rm -rf obj_dir sim.log

//--- design/cdcFifoFlops.sv
`timescale 1ns/1ps
`include "cdcFifo_defines.svh"

// Asynchronous FIFO with flop storage and ready/valid on both sides
// Cut-through latency is one push cycle plus NumSyncStages to
// NumSyncStages+1 pop cycles; a pop frees its slot on the push side after
// NumSyncStages to NumSyncStages+1 push cycles
module cdcFifoFlops #(
  parameter int Depth         = `CDC_FIFO_DEPTH,
  parameter int Width         = `CDC_FIFO_WIDTH,
  parameter int NumSyncStages = `CDC_FIFO_SYNC_STAGES
) (
  // Push domain
  input  logic               pushClk,
  input  logic               pushReset,
  input  logic               pushValid,
  input  logic [Width-1:0]   pushData,
  output logic               pushReady,
  output logic               pushFull,
  output cdcFifoPkg::countT  pushSlots,

  // Pop domain
  input  logic               popClk,
  input  logic               popReset,
  input  logic               popReady,
  output logic               popValid,
  output logic [Width-1:0]   popData,
  output logic               popEmpty,
  output cdcFifoPkg::countT  popItems
);

  // ------------------------------
  // Internal wiring
  // ------------------------------

  logic             ramWrValid;
  cdcFifoPkg::addrT ramWrAddr;
  logic [Width-1:0] ramWrData;
  cdcFifoPkg::addrT rdAddr;
  logic [Width-1:0] rdData;

  // Gray pointers, before and after their crossing
  cdcFifoPkg::ptrT  wrPtrGray;
  cdcFifoPkg::ptrT  wrPtrGraySynced;
  cdcFifoPkg::ptrT  rdPtrGray;
  cdcFifoPkg::ptrT  rdPtrGraySynced;

  // ------------------------------
  // Push domain
  // ------------------------------

  cdcFifoPushCtrl #(
    .Depth(Depth),
    .Width(Width)
  ) pushCtrl0 (
    .pushClk,
    .pushReset,
    .pushValid,
    .pushData,
    .pushReady,
    .pushFull,
    .pushSlots,
    .ramWrValid,
    .ramWrAddr,
    .ramWrData,
    .rdPtrGraySynced,
    .wrPtrGray
  );

  // Read pointer coming back from the pop domain
  cdcGraySync #(
    .syncT(cdcFifoPkg::ptrT),
    .NumSyncStages(NumSyncStages)
  ) rdPtrSync0 (
    .clk(pushClk),
    .reset(pushReset),
    .din(rdPtrGray),
    .dout(rdPtrGraySynced)
  );

  // The RAM is written on the push clock and read from the pop side
  cdcFlopRam #(
    .Depth(Depth),
    .Width(Width)
  ) ram0 (
    .wrClk(pushClk),
    .wrValid(ramWrValid),
    .wrAddr(ramWrAddr),
    .wrData(ramWrData),
    .rdAddr,
    .rdData
  );

  // ------------------------------
  // Pop domain
  // ------------------------------

  // Write pointer heading into the pop domain
  cdcGraySync #(
    .syncT(cdcFifoPkg::ptrT),
    .NumSyncStages(NumSyncStages)
  ) wrPtrSync0 (
    .clk(popClk),
    .reset(popReset),
    .din(wrPtrGray),
    .dout(wrPtrGraySynced)
  );

  cdcFifoPopCtrl #(
    .Depth(Depth),
    .Width(Width)
  ) popCtrl0 (
    .popClk,
    .popReset,
    .popReady,
    .popValid,
    .popData,
    .popEmpty,
    .popItems,
    .rdAddr,
    .rdData,
    .wrPtrGraySynced,
    .rdPtrGray
  );

endmodule : cdcFifoFlops

//--- design/cdcFifoPkg.sv
`include "cdcFifo_defines.svh"

package cdcFifoPkg;

  // Address into the flop RAM
  typedef logic [$clog2(`CDC_FIFO_DEPTH)-1:0] addrT;

  // Pointer with one bit above the address
  // The top bit flips on every wrap, so equal addresses can mean full or empty
  typedef logic [$clog2(`CDC_FIFO_DEPTH):0] ptrT;

  // Occupancy or free-slot count, which has to reach the full depth
  typedef logic [$clog2(`CDC_FIFO_DEPTH + 1)-1:0] countT;

  // Binary to Gray, so that a pointer step flips exactly one bit
  function automatic ptrT bin2gray(ptrT bin);
    return bin ^ (bin >> 1);
  endfunction

  // Gray back to binary, each bit folds in everything above it
  function automatic ptrT gray2bin(ptrT gray);
    ptrT bin;
    bin[$bits(ptrT)-1] = gray[$bits(ptrT)-1];
    for (int i = $bits(ptrT) - 2; i >= 0; i--) begin
      bin[i] = bin[i+1] ^ gray[i];
    end
    return bin;
  endfunction

endpackage : cdcFifoPkg

//--- design/cdcFifoPopCtrl.sv
`timescale 1ns/1ps
`include "cdcFifo_defines.svh"

// Pop side of the asynchronous FIFO
// It owns the read pointer, reads the RAM at that pointer and counts the items
// from the write pointer that came across from the push domain
module cdcFifoPopCtrl #(
  parameter int Depth = `CDC_FIFO_DEPTH,
  parameter int Width = `CDC_FIFO_WIDTH
) (
  input  logic               popClk,
  input  logic               popReset,

  // Ready/valid pop interface
  input  logic               popReady,
  output logic               popValid,
  output logic [Width-1:0]   popData,

  // Status as seen from the pop domain
  output logic               popEmpty,
  output cdcFifoPkg::countT  popItems,

  // RAM read port
  output cdcFifoPkg::addrT   rdAddr,
  input  logic [Width-1:0]   rdData,

  // Pointers crossing between the domains
  input  cdcFifoPkg::ptrT    wrPtrGraySynced,
  output cdcFifoPkg::ptrT    rdPtrGray
);

  // The wrap bit sits right above the address bits
  localparam int PtrMsb = $clog2(Depth);

  cdcFifoPkg::ptrT rdPtr;
  cdcFifoPkg::ptrT rdPtrNext;
  cdcFifoPkg::ptrT wrPtrSynced;
  cdcFifoPkg::ptrT itemCount;
  logic            popXfer;

  // ------------------------------
  // Read pointer
  // ------------------------------

  assign popXfer   = popValid & popReady;
  assign rdPtrNext = rdPtr + cdcFifoPkg::ptrT'(popXfer);

  // Registered Gray copy for the trip back to the push domain
  always_ff @(posedge popClk) begin
    if (popReset) begin
      rdPtr     <= '0;
      rdPtrGray <= '0;
    end else begin
      rdPtr     <= rdPtrNext;
      rdPtrGray <= cdcFifoPkg::bin2gray(rdPtrNext);
    end
  end

  // ------------------------------
  // Empty and item accounting
  // ------------------------------

  // The write pointer seen here is late, so items are undercounted and the
  // pop side never runs into a word that is still being written
  assign wrPtrSynced = cdcFifoPkg::gray2bin(wrPtrGraySynced);
  assign itemCount   = wrPtrSynced - rdPtr;

  assign popEmpty = (itemCount == '0);
  assign popValid = ~popEmpty;

  // The push side never runs more than Depth ahead of a read pointer it has
  // seen, so the difference goes out as it is
  assign popItems = cdcFifoPkg::countT'(itemCount);

  // ------------------------------
  // Read data
  // ------------------------------

  // The head word sits at the read pointer and the push side cannot
  // overwrite it until this pointer moves, so popData holds while stalled
  assign rdAddr  = rdPtr[PtrMsb-1:0];
  assign popData = rdData;

endmodule : cdcFifoPopCtrl

//--- design/cdcFifoPushCtrl.sv
`timescale 1ns/1ps
`include "cdcFifo_defines.svh"

// Push side of the asynchronous FIFO
// It owns the write pointer, writes the RAM and works out how many slots are
// free from the read pointer that came across from the pop domain
module cdcFifoPushCtrl #(
  parameter int Depth = `CDC_FIFO_DEPTH,
  parameter int Width = `CDC_FIFO_WIDTH
) (
  input  logic               pushClk,
  input  logic               pushReset,

  // Ready/valid push interface
  input  logic               pushValid,
  input  logic [Width-1:0]   pushData,
  output logic               pushReady,

  // Status, seen from the push domain
  output logic               pushFull,
  output cdcFifoPkg::countT  pushSlots,

  // RAM write port
  output logic               ramWrValid,
  output cdcFifoPkg::addrT   ramWrAddr,
  output logic [Width-1:0]   ramWrData,

  // Pointers crossing between the domains
  input  cdcFifoPkg::ptrT    rdPtrGraySynced,
  output cdcFifoPkg::ptrT    wrPtrGray
);

  localparam int PtrMsb = $bits(cdcFifoPkg::ptrT) - 1;

  cdcFifoPkg::ptrT wrPtr;
  cdcFifoPkg::ptrT wrPtrNext;
  cdcFifoPkg::ptrT rdPtrSynced;
  cdcFifoPkg::ptrT usedCount;
  logic            pushXfer;

  // ------------------------------
  // Write pointer
  // ------------------------------

  assign pushXfer  = pushValid & pushReady;
  assign wrPtrNext = wrPtr + cdcFifoPkg::ptrT'(pushXfer);

  // The Gray copy is a flop of its own, so no decode glitch can reach the
  // synchronizer in the pop domain
  always_ff @(posedge pushClk) begin
    if (pushReset) begin
      wrPtr     <= '0;
      wrPtrGray <= '0;
    end else begin
      wrPtr     <= wrPtrNext;
      wrPtrGray <= cdcFifoPkg::bin2gray(wrPtrNext);
    end
  end

  // ------------------------------
  // Full and slot accounting
  // ------------------------------

  // The read pointer here lags the real one, so slots can only be
  // undercounted and the FIFO never overflows
  assign rdPtrSynced = cdcFifoPkg::gray2bin(rdPtrGraySynced);
  assign usedCount   = wrPtr - rdPtrSynced;

  // Full when the write pointer is one whole lap ahead: same address,
  // opposite wrap bit
  assign pushFull  = (wrPtr[PtrMsb] != rdPtrSynced[PtrMsb]) &&
                     (wrPtr[PtrMsb-1:0] == rdPtrSynced[PtrMsb-1:0]);
  assign pushReady = ~pushFull;
  assign pushSlots = cdcFifoPkg::countT'(Depth) - cdcFifoPkg::countT'(usedCount);

  // ------------------------------
  // RAM write
  // ------------------------------

  // The word lands on the same edge that moves the write pointer
  assign ramWrValid = pushXfer;
  assign ramWrAddr  = wrPtr[PtrMsb-1:0];
  assign ramWrData  = pushData;

endmodule : cdcFifoPushCtrl

//--- design/cdcFifo_defines.svh
`ifndef CDC_FIFO_DEFINES_SVH
`define CDC_FIFO_DEFINES_SVH

// ------------------------------
// Default FIFO geometry
// ------------------------------

// Number of FIFO entries, a power of two and at least 2
// The extra pointer bit only tells full from empty when the depth is a power of two
`define CDC_FIFO_DEPTH 8

// Payload width in bits
`define CDC_FIFO_WIDTH 16

// ------------------------------
// Clock-domain crossing
// ------------------------------

// Flops in each Gray pointer synchronizer, at least 2
// A third stage buys extra settling time for metastability
`define CDC_FIFO_SYNC_STAGES 3

`endif

//--- design/cdcFlopRam.sv
`timescale 1ns/1ps
`include "cdcFifo_defines.svh"

// Flop storage for the FIFO entries
// Written in the push domain, read without a clock from the pop domain
module cdcFlopRam #(
  parameter int Depth = `CDC_FIFO_DEPTH,
  parameter int Width = `CDC_FIFO_WIDTH
) (
  // Write port, on the push clock
  input  logic              wrClk,
  input  logic              wrValid,
  input  cdcFifoPkg::addrT  wrAddr,
  input  logic [Width-1:0]  wrData,

  // Read port, a plain multiplexer
  input  cdcFifoPkg::addrT  rdAddr,
  output logic [Width-1:0]  rdData
);

  // ------------------------------
  // Storage
  // ------------------------------

  // Words come up undefined
  // The pop side only looks at a word after its write pointer has crossed
  logic [Width-1:0] mem [Depth];

  always_ff @(posedge wrClk) begin
    if (wrValid) begin
      mem[wrAddr] <= wrData;
    end
  end

  // ------------------------------
  // Read
  // ------------------------------

  // The addressed word is stable by the time its pointer is visible on the
  // pop side, so the unclocked read does not sample a changing value
  assign rdData = mem[rdAddr];

endmodule : cdcFlopRam

//--- design/cdcGraySync.sv
`timescale 1ns/1ps
`include "cdcFifo_defines.svh"

// Flop chain that brings a Gray-coded value into the clock domain of clk
// Only one bit of the value changes per source edge, so a sampled value is
// always either the old pointer or the new one
module cdcGraySync #(
  parameter type syncT = logic,
  parameter int NumSyncStages = `CDC_FIFO_SYNC_STAGES
) (
  input  logic clk,
  input  logic reset,
  input  syncT din,
  output syncT dout
);

  // Stage 0 is the flop that may go metastable
  // The later stages give it time to settle
  syncT stages [NumSyncStages];

  always_ff @(posedge clk) begin
    if (reset) begin
      stages <= '{default: '0};
    end else begin
      stages[0] <= din;
      for (int i = 1; i < NumSyncStages; i++) begin
        stages[i] <= stages[i-1];
      end
    end
  end

  // The value seen here is din from exactly NumSyncStages edges ago
  assign dout = stages[NumSyncStages-1];

endmodule : cdcGraySync

//--- flist.f
+incdir+design
design/cdcFifoPkg.sv
design/cdcGraySync.sv
design/cdcFifoPushCtrl.sv
design/cdcFifoPopCtrl.sv
design/cdcFlopRam.sv
design/cdcFifoFlops.sv
verification/cdcFifo_chk.sv
verification/cdcFifoTb.sv

//--- verification/cdcFifoTb.sv
`timescale 1ns/1ps
`include "cdcFifo_defines.svh"

module cdcFifoTb;

  localparam int Depth       = `CDC_FIFO_DEPTH;
  localparam int Width       = `CDC_FIFO_WIDTH;
  localparam int TotalPushes = 300;
  localparam int WaitLimit   = 3000;
  localparam int MaxPhases   = 200;

  logic              pushClk;
  logic              pushReset;
  logic              pushValid;
  logic [Width-1:0]  pushData;
  logic              pushReady;
  logic              pushFull;
  cdcFifoPkg::countT pushSlots;
  logic              popClk;
  logic              popReset;
  logic              popReady;
  logic              popValid;
  logic [Width-1:0]  popData;
  logic              popEmpty;
  cdcFifoPkg::countT popItems;

  // Percent chance per cycle of offering a push or accepting a pop
  int pushPct;
  int popPct;
  int pushedCount;
  int poppedCount;

  // Pushed words in order that wait for their pop
  logic [Width-1:0] expQ [$];

  cdcFifoFlops #(
    .Depth(Depth),
    .Width(Width),
    .NumSyncStages(`CDC_FIFO_SYNC_STAGES)
  ) dut0 (
    .pushClk, .pushReset, .pushValid, .pushData, .pushReady, .pushFull, .pushSlots,
    .popClk, .popReset, .popReady, .popValid, .popData, .popEmpty, .popItems
  );

  // Unrelated periods, so the edges drift against each other
  always #5 pushClk = ~pushClk;
  always #6.5 popClk = ~popClk;

  task automatic stopOnFailure();
    $display("CHECKS FAILED");
    $fatal(1);
  endtask

  task automatic reportMismatch(string testName, logic [31:0] expected, logic [31:0] actual);
    $display("CHECK FAILED: %s expected %0h actual %0h", testName, expected, actual);
    stopOnFailure();
  endtask

  task automatic reportFailure(string what);
    $display("FAILURE: %s", what);
    stopOnFailure();
  endtask

  // ------------------------------
  // Each reset holds for two cycles of its own clock
  // ------------------------------
  initial begin
    repeat (2) @(posedge pushClk);
    pushReset <= 1'b0;
  end

  initial begin
    repeat (2) @(posedge popClk);
    popReset <= 1'b0;
  end

  // Push source
  // A word once offered stays put until it is taken
  always @(posedge pushClk) begin
    if (pushReset) begin
      pushValid <= 1'b0;
    end else begin
      if (pushValid && pushReady) begin
        expQ.push_back(pushData);
        pushedCount++;
      end
      if (!pushValid || pushReady) begin
        if (pushedCount < TotalPushes && $urandom_range(99) < pushPct) begin
          pushValid <= 1'b1;
          // Data is the running count, so the pop order is known up front
          pushData  <= Width'(pushedCount);
        end else begin
          pushValid <= 1'b0;
        end
      end
    end
  end

  // Pop sink with the in-order scoreboard
  always @(posedge popClk) begin
    if (popReset) begin
      popReady <= 1'b0;
    end else begin
      if (popValid && popReady) begin
        if (expQ.size() == 0) begin
          reportFailure("the FIFO popped a word that was never pushed");
        end else if (popData !== expQ[0]) begin
          reportMismatch("in-order data", expQ[0], popData);
        end else begin
          void'(expQ.pop_front());
          poppedCount++;
        end
      end
      popReady <= ($urandom_range(99) < popPct);
    end
  end

  // The bound checker counts its failed assertions
  always @(negedge pushClk) begin
    if (dut0.chk0.failCount != 0) begin
      reportFailure("a protocol assertion fired");
    end
  end

  // ------------------------------
  // Test phases
  // ------------------------------
  initial begin
    int waitCount;
    int phaseCount;
    void'($urandom(32'h4754b235));
    pushClk     = 1'b0;
    popClk      = 1'b0;
    pushReset   = 1'b1;
    popReset    = 1'b1;
    pushValid   = 1'b0;
    pushData    = '0;
    popReady    = 1'b0;
    pushPct     = 0;
    popPct      = 0;
    pushedCount = 0;
    poppedCount = 0;

    waitCount = 0;
    while (pushReset || popReset) begin
      @(negedge pushClk);
      waitCount++;
      if (waitCount > WaitLimit) reportFailure("the resets were never released");
    end

    // Fill with the pop side stalled until back-pressure shows
    pushPct   = 100;
    popPct    = 0;
    waitCount = 0;
    while (!pushFull) begin
      @(negedge pushClk);
      waitCount++;
      if (waitCount > WaitLimit) reportFailure("the FIFO never filled with pops stalled");
    end
    repeat (20) @(negedge pushClk);
    if (pushedCount != Depth) reportMismatch("fill level", Depth, pushedCount);

    // Drain with pushes off
    pushPct   = 0;
    popPct    = 100;
    waitCount = 0;
    while (pushValid || expQ.size() != 0 || !popEmpty) begin
      @(negedge popClk);
      waitCount++;
      if (waitCount > WaitLimit) reportFailure("the FIFO did not empty after the fill");
    end

    // Mixed traffic picks new rates every 40 push cycles
    phaseCount = 0;
    while (pushedCount < TotalPushes) begin
      pushPct = $urandom_range(100, 20);
      popPct  = $urandom_range(100, 20);
      repeat (40) @(negedge pushClk);
      phaseCount++;
      if (phaseCount > MaxPhases) reportFailure("mixed traffic stalled before all pushes");
    end

    // Final drain
    pushPct   = 0;
    popPct    = 100;
    waitCount = 0;
    while (pushValid || expQ.size() != 0 || !popEmpty) begin
      @(negedge popClk);
      waitCount++;
      if (waitCount > WaitLimit) reportFailure("popEmpty did not return after the drain");
    end
    if (poppedCount != TotalPushes) reportMismatch("pop count", TotalPushes, poppedCount);

    // The last pops need a trip through the synchronizer to free their slots
    waitCount = 0;
    while (pushSlots != cdcFifoPkg::countT'(Depth)) begin
      @(negedge pushClk);
      waitCount++;
      if (waitCount > WaitLimit) reportFailure("pushSlots did not return to the depth");
    end

    if (dut0.chk0.failCount != 0) begin
      reportFailure("a protocol assertion fired near the end of the run");
    end else begin
      $display("ALL CHECKS PASSED");
      $finish;
    end
  end

endmodule : cdcFifoTb

//--- verification/cdcFifo_chk.sv
`timescale 1ns/1ps
`include "cdcFifo_defines.svh"

// Protocol and status checks on the FIFO ports
module cdcFifoChk #(
  parameter int Depth = `CDC_FIFO_DEPTH,
  parameter int Width = `CDC_FIFO_WIDTH
) (
  input logic              pushClk,
  input logic              pushReset,
  input logic              pushValid,
  input logic              pushReady,
  input logic              pushFull,
  input cdcFifoPkg::countT pushSlots,
  input logic              popClk,
  input logic              popReset,
  input logic              popReady,
  input logic              popValid,
  input logic [Width-1:0]  popData,
  input logic              popEmpty,
  input cdcFifoPkg::countT popItems
);

  // Read by the testbench
  int failCount = 0;

  // ------------------------------
  // Push domain
  // ------------------------------
  readyMirrorsFull: assert property (@(posedge pushClk) disable iff (pushReset)
    pushReady == !pushFull)
    else begin
      $error("pushReady is not the inverse of pushFull");
      failCount++;
    end

  fullMeansNoSlots: assert property (@(posedge pushClk) disable iff (pushReset)
    pushFull |-> pushSlots == '0)
    else begin
      $error("pushSlots is not 0 while full");
      failCount++;
    end

  // A transfer only goes through while the slot count shows room
  noPushWhileFull: assert property (@(posedge pushClk) disable iff (pushReset)
    (pushValid && pushReady) |-> pushSlots != '0)
    else begin
      $error("push accepted with no free slot");
      failCount++;
    end

  slotsInRange: assert property (@(posedge pushClk) disable iff (pushReset)
    pushSlots <= cdcFifoPkg::countT'(Depth))
    else begin
      $error("pushSlots exceeds the depth");
      failCount++;
    end

  pushResetState: assert property (@(posedge pushClk)
    pushReset |=> pushSlots == cdcFifoPkg::countT'(Depth))
    else begin
      $error("pushSlots is not the depth after reset");
      failCount++;
    end

  // ------------------------------
  // Pop domain
  // ------------------------------
  validMirrorsEmpty: assert property (@(posedge popClk) disable iff (popReset)
    popValid == !popEmpty)
    else begin
      $error("popValid is not the inverse of popEmpty");
      failCount++;
    end

  emptyMeansNoItems: assert property (@(posedge popClk) disable iff (popReset)
    popEmpty |-> popItems == '0)
    else begin
      $error("popItems is not 0 while empty");
      failCount++;
    end

  itemsInRange: assert property (@(posedge popClk) disable iff (popReset)
    popItems <= cdcFifoPkg::countT'(Depth))
    else begin
      $error("popItems exceeds the depth");
      failCount++;
    end

  // A stalled head word stays offered and unchanged
  popDataHeld: assert property (@(posedge popClk) disable iff (popReset)
    (popValid && !popReady) |=> (popValid && $stable(popData)))
    else begin
      $error("popData changed while stalled");
      failCount++;
    end

  popResetState: assert property (@(posedge popClk)
    popReset |=> (!popValid && popItems == '0))
    else begin
      $error("pop side not empty after reset");
      failCount++;
    end

endmodule : cdcFifoChk

bind cdcFifoFlops cdcFifoChk #(.Depth(Depth), .Width(Width)) chk0 (
  .pushClk(pushClk), .pushReset(pushReset), .pushValid(pushValid), .pushReady(pushReady),
  .pushFull(pushFull), .pushSlots(pushSlots), .popClk(popClk), .popReset(popReset),
  .popReady(popReady), .popValid(popValid), .popData(popData), .popEmpty(popEmpty),
  .popItems(popItems)
);
